//--- list.f
src/fault_summary_pkg.sv
src/supply_monitor_bank.sv
src/mcu_fault_decode.sv
src/errmon_ack_timer.sv
src/fault_aggregator.sv
src/fault_summary_top.sv
tests/tb_fault_summary.sv

//--- src/errmon_ack_timer.sv
module errmon_ack_timer
    import fault_summary_pkg::*;
#(
    parameter int clocks_per_ms = 20000
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          errmon,           // external ic error report
    input  logic          errmon_ack,       // level ack from the mcu
    input  logic [1:0]    errmon_ack_time,  // 1, 8, 16 or 32 ms
    input  logic          errmon_fs_impact,
    output fault_action_t action,
    output flt_cnt_t      events
);

    localparam int presc_w = (clocks_per_ms > 1) ? $clog2(clocks_per_ms) : 1;

    logic               errmon_q;
    logic               errmon_rise;
    logic               busy;
    logic               expire_q;
    logic               ms_tick;
    logic [presc_w-1:0] presc_cnt;
    logic [4:0]         ms_cnt;
    logic [4:0]         ms_last;

    assign errmon_rise = errmon & ~errmon_q;
    assign ms_tick     = busy && (presc_cnt == presc_w'(clocks_per_ms - 1));

    // last millisecond index of the window
    always_comb begin
        case (errmon_ack_time)
            2'b00:   ms_last = 5'd0;
            2'b01:   ms_last = 5'd7;
            2'b10:   ms_last = 5'd15;
            default: ms_last = 5'd31;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            errmon_q  <= 1'b0;
            busy      <= 1'b0;
            expire_q  <= 1'b0;
            presc_cnt <= '0;
            ms_cnt    <= '0;
        end else begin
            errmon_q <= errmon;
            expire_q <= 1'b0;
            if (errmon_rise) begin
                // a new report restarts the window
                busy      <= 1'b1;
                presc_cnt <= '0;
                ms_cnt    <= '0;
            end else if (busy) begin
                if (errmon_ack) begin
                    busy <= 1'b0; // acked in time, nothing reported
                end else if (ms_tick) begin
                    presc_cnt <= '0;
                    if (ms_cnt == ms_last) begin
                        busy     <= 1'b0;
                        expire_q <= 1'b1;
                    end else begin
                        ms_cnt <= ms_cnt + 5'd1;
                    end
                end else begin
                    presc_cnt <= presc_cnt + 1'b1;
                end
            end
        end
    end

    // the timeout pulse only ever closes a running window
    a_no_event_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        expire_q |-> ($past(busy) && !busy)
    ) else $error("errmon timeout without a running timer");

    always_comb begin
        action.mask    = 3'b000;
        action.f.fs0b  = expire_q;
        action.f.rstb  = expire_q & errmon_fs_impact;
        action.f.pgood = 1'b0;
    end

    assign events = flt_cnt_t'(expire_q);

endmodule

//--- src/fault_aggregator.sv
module fault_aggregator
    import fault_summary_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  fault_action_t supply_action,
    input  fault_action_t mcu_action,
    input  fault_action_t errmon_action,
    input  flt_cnt_t      supply_events,
    input  flt_cnt_t      mcu_events,
    input  flt_cnt_t      errmon_events,
    input  logic          decr,              // from the watchdog
    input  logic [1:0]    flt_err_impact,
    input  flt_limit_t    flt_err_cnt_limit,
    output logic          fs0b_active,
    output logic          rstb_active,
    output logic          pgood_active,
    output flt_cnt_t      flt_err_cnt,
    output logic          flag_flt_max
);

    logic [4:0]    evt_sum;
    logic [4:0]    cnt_add;
    flt_cnt_t      incr_q;
    flt_cnt_t      cnt_max;
    flt_cnt_t      cnt_mid;
    fault_action_t mid_action;
    fault_action_t merged;

    assign cnt_max = flt_max_for_limit(flt_err_cnt_limit);
    assign cnt_mid = flt_intermediate_for_limit(flt_err_cnt_limit);

    // worst case is 18 events, clipped below since the counter saturates anyway
    assign evt_sum = 5'(supply_events) + 5'(mcu_events) + 5'(errmon_events);
    assign cnt_add = 5'(flt_err_cnt) + 5'(incr_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            incr_q <= '0;
        end else if (evt_sum > 5'd15) begin
            incr_q <= 4'd15;
        end else begin
            incr_q <= evt_sum[3:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flt_err_cnt <= '0;
        end else if (incr_q != '0) begin
            if (cnt_add >= 5'(cnt_max)) begin
                flt_err_cnt <= cnt_max; // saturate
            end else begin
                flt_err_cnt <= cnt_add[3:0];
            end
        end else if (flt_err_cnt > cnt_max) begin
            // limit lowered at run time
            flt_err_cnt <= cnt_max;
        end else if (decr && (flt_err_cnt != '0)) begin
            flt_err_cnt <= flt_err_cnt - 4'd1;
        end
    end

    assign flag_flt_max = (flt_err_cnt == cnt_max);

    // intermediate value action
    always_comb begin
        mid_action.mask    = 3'b000;
        mid_action.f.fs0b  = (flt_err_cnt == cnt_mid) && (|flt_err_impact);
        mid_action.f.rstb  = (flt_err_cnt >= cnt_mid) && flt_err_impact[1];
        mid_action.f.pgood = 1'b0;
    end

    always_comb begin
        merged.mask = supply_action.mask
                    | mcu_action.mask
                    | errmon_action.mask
                    | mid_action.mask;
    end

    assign fs0b_active  = merged.f.fs0b;
    assign rstb_active  = merged.f.rstb;
    assign pgood_active = merged.f.pgood;

    // counter stays within the selected limit once the selector has settled
    a_cnt_le_max: assert property (
        @(posedge clk) disable iff (!rst_n)
        $stable(flt_err_cnt_limit) |-> (flt_err_cnt <= cnt_max)
    ) else $error("fault error counter %0d above max %0d", flt_err_cnt, cnt_max);

endmodule

//--- src/fault_summary_pkg.sv
package fault_summary_pkg;

    // vcore, vddio and vmon1..4, each with an ov and a uv channel
    localparam int num_supply_channels = 12;

    // impact bit 0 asks for fs0b, bit 1 for rstb
    typedef logic [1:0] fs_impact_t;

    typedef logic [3:0] flt_cnt_t;   // counter value and per-cycle event count
    typedef logic [1:0] flt_limit_t; // counter limit selector

    // one action word, merged as a mask or read field by field
    typedef union packed {
        logic [2:0] mask;
        struct packed {
            logic fs0b;
            logic rstb;
            logic pgood;
        } f;
    } fault_action_t;

    // saturation point of the fault error counter
    function automatic flt_cnt_t flt_max_for_limit(input flt_limit_t sel);
        case (sel)
            2'b00:   return 4'd2;
            2'b01:   return 4'd6;
            2'b10:   return 4'd8;
            default: return 4'd12;
        endcase
    endfunction

    // value that triggers the intermediate action
    function automatic flt_cnt_t flt_intermediate_for_limit(input flt_limit_t sel);
        case (sel)
            2'b00:   return 4'd1;
            2'b01:   return 4'd3;
            2'b10:   return 4'd4;
            default: return 4'd6;
        endcase
    endfunction

endpackage

//--- src/fault_summary_top.sv
module fault_summary_top
    import fault_summary_pkg::*;
#(
    parameter int clocks_per_ms = 20000 // 1 ms at 20 MHz
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       vcore_ov,
    input  logic       vcore_uv,
    input  logic       vddio_ov,
    input  logic       vddio_uv,
    input  logic [3:0] vmonx_ov,          // vmon1..vmon4
    input  logic [3:0] vmonx_uv,
    input  logic       fccu1,
    input  logic       fccu2,
    input  logic       fccu12,
    input  logic       errmon,
    input  logic       errmon_ack,
    input  logic [1:0] errmon_ack_time,
    input  logic       incr_a,
    input  logic       incr_b,
    input  logic       decr,
    input  fs_impact_t vcore_ov_fs_impact,
    input  fs_impact_t vcore_uv_fs_impact,
    input  fs_impact_t vddio_ov_fs_impact,
    input  fs_impact_t vddio_uv_fs_impact,
    input  fs_impact_t vmon1_ov_fs_impact,
    input  fs_impact_t vmon1_uv_fs_impact,
    input  fs_impact_t vmon2_ov_fs_impact,
    input  fs_impact_t vmon2_uv_fs_impact,
    input  fs_impact_t vmon3_ov_fs_impact,
    input  fs_impact_t vmon3_uv_fs_impact,
    input  fs_impact_t vmon4_ov_fs_impact,
    input  fs_impact_t vmon4_uv_fs_impact,
    input  logic       fccu1_fs_impact,
    input  logic       fccu2_fs_impact,
    input  logic       fccu12_fs_impact,
    input  logic       errmon_fs_impact,
    input  fs_impact_t wd_fs_impact,
    input  logic [1:0] flt_err_impact,
    input  flt_limit_t flt_err_cnt_limit,
    input  logic       otp_pgood_vcore,
    input  logic       otp_pgood_vddio,
    input  logic       otp_pgood_vmon1,
    input  logic       otp_pgood_vmon2,
    input  logic       otp_pgood_vmon3,
    input  logic       otp_pgood_vmon4,
    output logic       fs0b_active,
    output logic       rstb_active,
    output logic       pgood_active,
    output flt_cnt_t   flt_err_cnt,
    output logic       flag_flt_max,
    output logic       fccu_err
);

    // channel order: vcore ov/uv, vddio ov/uv, then vmon1..4 ov/uv
    logic       [num_supply_channels-1:0] mon_vec;
    fs_impact_t [num_supply_channels-1:0] impact_vec;
    logic       [num_supply_channels-1:0] pgood_vec;

    fault_action_t supply_action, mcu_action, errmon_action;
    flt_cnt_t      supply_events, mcu_events, errmon_events;

    assign mon_vec = {vmonx_uv[3], vmonx_ov[3], vmonx_uv[2], vmonx_ov[2],
                      vmonx_uv[1], vmonx_ov[1], vmonx_uv[0], vmonx_ov[0],
                      vddio_uv, vddio_ov, vcore_uv, vcore_ov};

    assign impact_vec = {vmon4_uv_fs_impact, vmon4_ov_fs_impact,
                         vmon3_uv_fs_impact, vmon3_ov_fs_impact,
                         vmon2_uv_fs_impact, vmon2_ov_fs_impact,
                         vmon1_uv_fs_impact, vmon1_ov_fs_impact,
                         vddio_uv_fs_impact, vddio_ov_fs_impact,
                         vcore_uv_fs_impact, vcore_ov_fs_impact};

    // ov and uv of one supply share the pgood enable
    assign pgood_vec = {{2{otp_pgood_vmon4}}, {2{otp_pgood_vmon3}},
                        {2{otp_pgood_vmon2}}, {2{otp_pgood_vmon1}},
                        {2{otp_pgood_vddio}}, {2{otp_pgood_vcore}}};

    supply_monitor_bank i_supply (
        .clk      (clk),
        .rst_n    (rst_n),
        .mon      (mon_vec),
        .impact   (impact_vec),
        .pgood_en (pgood_vec),
        .action   (supply_action),
        .events   (supply_events)
    );

    mcu_fault_decode i_mcu (
        .fccu1            (fccu1),
        .fccu2            (fccu2),
        .fccu12           (fccu12),
        .fccu1_fs_impact  (fccu1_fs_impact),
        .fccu2_fs_impact  (fccu2_fs_impact),
        .fccu12_fs_impact (fccu12_fs_impact),
        .incr_a           (incr_a),
        .incr_b           (incr_b),
        .wd_fs_impact     (wd_fs_impact),
        .action           (mcu_action),
        .events           (mcu_events),
        .fccu_err         (fccu_err)
    );

    errmon_ack_timer #(
        .clocks_per_ms (clocks_per_ms)
    ) i_errmon (
        .clk              (clk),
        .rst_n            (rst_n),
        .errmon           (errmon),
        .errmon_ack       (errmon_ack),
        .errmon_ack_time  (errmon_ack_time),
        .errmon_fs_impact (errmon_fs_impact),
        .action           (errmon_action),
        .events           (errmon_events)
    );

    fault_aggregator i_agg (
        .clk               (clk),
        .rst_n             (rst_n),
        .supply_action     (supply_action),
        .mcu_action        (mcu_action),
        .errmon_action     (errmon_action),
        .supply_events     (supply_events),
        .mcu_events        (mcu_events),
        .errmon_events     (errmon_events),
        .decr              (decr),
        .flt_err_impact    (flt_err_impact),
        .flt_err_cnt_limit (flt_err_cnt_limit),
        .fs0b_active       (fs0b_active),
        .rstb_active       (rstb_active),
        .pgood_active      (pgood_active),
        .flt_err_cnt       (flt_err_cnt),
        .flag_flt_max      (flag_flt_max)
    );

endmodule

//--- src/mcu_fault_decode.sv
module mcu_fault_decode
    import fault_summary_pkg::*;
(
    input  logic          fccu1,
    input  logic          fccu2,
    input  logic          fccu12,
    input  logic          fccu1_fs_impact,
    input  logic          fccu2_fs_impact,
    input  logic          fccu12_fs_impact,
    input  logic          incr_a,       // wd error counter at max
    input  logic          incr_b,       // bad or missing wd refresh
    input  fs_impact_t    wd_fs_impact,
    output fault_action_t action,
    output flt_cnt_t      events,
    output logic          fccu_err
);

    logic fccu_rstb;
    logic wd_a_hit;
    logic wd_a_rstb;

    assign fccu_err = fccu1 | fccu2 | fccu12;

    // rstb only where the line's impact bit asks for it
    assign fccu_rstb = (fccu1 & fccu1_fs_impact)
                     | (fccu2 & fccu2_fs_impact)
                     | (fccu12 & fccu12_fs_impact);

    // incr_a acts only with a nonzero impact
    assign wd_a_hit  = incr_a & (|wd_fs_impact);
    assign wd_a_rstb = incr_a & wd_fs_impact[1];

    always_comb begin
        action.mask   = 3'b000;
        action.f.fs0b = fccu_err | wd_a_hit | incr_b;
        action.f.rstb = fccu_rstb | wd_a_rstb | incr_b; // incr_b always resets
        action.f.pgood = 1'b0;                          // no pgood request from the mcu side
    end

    // one event per active source
    always_comb begin
        events = flt_cnt_t'(fccu1)
               + flt_cnt_t'(fccu2)
               + flt_cnt_t'(fccu12)
               + flt_cnt_t'(wd_a_hit)
               + flt_cnt_t'(incr_b);
    end

endmodule

//--- src/supply_monitor_bank.sv
module supply_monitor_bank
    import fault_summary_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic       [num_supply_channels-1:0] mon,      // ov/uv comparator outputs
    input  fs_impact_t [num_supply_channels-1:0] impact,
    input  logic       [num_supply_channels-1:0] pgood_en, // otp pgood enable per channel
    output fault_action_t                        action,
    output flt_cnt_t                             events
);

    logic [1:0]                     hist_q [num_supply_channels]; // [0] newest sample
    logic [num_supply_channels-1:0] rise;
    fault_action_t                  ch_act [num_supply_channels];

    // pgood wins over the impact setting, then rstb over fs0b alone
    function automatic fault_action_t decode_channel(
        input logic       hit,
        input fs_impact_t imp,
        input logic       pg
    );
        fault_action_t act;
        act.mask = 3'b000;
        if (hit) begin
            if (pg) begin
                act.mask = 3'b111;
            end else if (imp[1]) begin
                act.f.fs0b = 1'b1;
                act.f.rstb = 1'b1;
            end else if (imp[0]) begin
                act.f.fs0b = 1'b1;
            end
        end
        return act;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_supply_channels; i++) begin
                hist_q[i] <= 2'b00;
            end
        end else begin
            for (int i = 0; i < num_supply_channels; i++) begin
                hist_q[i] <= {hist_q[i][0], mon[i]};
            end
        end
    end

    for (genvar g = 0; g < num_supply_channels; g++) begin : g_ch
        assign rise[g]   = hist_q[g][0] & ~hist_q[g][1]; // first cycle seen high
        assign ch_act[g] = decode_channel(rise[g], impact[g], pgood_en[g]);

        // a monitor held high must not re-trigger
        a_event_one_cycle: assert property (
            @(posedge clk) disable iff (!rst_n)
            (|ch_act[g].mask) |=> !(|ch_act[g].mask)
        ) else $error("supply channel %0d event longer than one cycle", g);
    end

    // merge channels
    always_comb begin
        action.mask = 3'b000;
        events      = '0;
        for (int i = 0; i < num_supply_channels; i++) begin
            action.mask = action.mask | ch_act[i].mask;
            events      = events + flt_cnt_t'(|ch_act[i].mask); // only channels that acted
        end
    end

endmodule

//--- tests/tb_fault_summary.sv
module tb_fault_summary;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int cpm = 20; // clocks per ms, short for simulation
    localparam int max_tab [4] = '{2, 6, 8, 12};
    localparam int mid_tab [4] = '{1, 3, 4, 6};
    localparam int ms_tab  [4] = '{1, 8, 16, 32};

    logic       clk;
    logic       rst_n;
    logic       fccu1, fccu2, fccu12, fccu_err;
    logic       errmon, errmon_ack, errmon_fs_impact;
    logic [1:0] errmon_ack_time;
    logic       incr_a, incr_b, decr;
    logic       fccu1_fs_impact, fccu2_fs_impact, fccu12_fs_impact;
    logic [1:0] wd_fs_impact, flt_err_impact, flt_err_cnt_limit;
    logic       fs0b_active, rstb_active, pgood_active, flag_flt_max;
    logic [3:0] flt_err_cnt;
    wire        vcore_ov, vcore_uv, vddio_ov, vddio_uv;
    wire  [3:0] vmonx_ov, vmonx_uv;
    wire  [1:0] vcore_ov_fs_impact, vcore_uv_fs_impact, vddio_ov_fs_impact, vddio_uv_fs_impact;
    wire  [1:0] vmon1_ov_fs_impact, vmon1_uv_fs_impact, vmon2_ov_fs_impact, vmon2_uv_fs_impact;
    wire  [1:0] vmon3_ov_fs_impact, vmon3_uv_fs_impact, vmon4_ov_fs_impact, vmon4_uv_fs_impact;
    wire        otp_pgood_vcore, otp_pgood_vddio, otp_pgood_vmon1;
    wire        otp_pgood_vmon2, otp_pgood_vmon3, otp_pgood_vmon4;

    logic [11:0]      mon_bits; // vcore ov/uv, vddio ov/uv, vmon1..4 ov/uv
    logic [11:0][1:0] imp_cfg;
    logic [5:0]       pg_cfg;   // one enable per supply
    int               seed;

    assign {vmonx_uv[3], vmonx_ov[3], vmonx_uv[2], vmonx_ov[2], vmonx_uv[1], vmonx_ov[1],
            vmonx_uv[0], vmonx_ov[0], vddio_uv, vddio_ov, vcore_uv, vcore_ov} = mon_bits;
    assign {vmon4_uv_fs_impact, vmon4_ov_fs_impact, vmon3_uv_fs_impact, vmon3_ov_fs_impact,
            vmon2_uv_fs_impact, vmon2_ov_fs_impact, vmon1_uv_fs_impact, vmon1_ov_fs_impact,
            vddio_uv_fs_impact, vddio_ov_fs_impact, vcore_uv_fs_impact,
            vcore_ov_fs_impact} = imp_cfg;
    assign {otp_pgood_vmon4, otp_pgood_vmon3, otp_pgood_vmon2, otp_pgood_vmon1,
            otp_pgood_vddio, otp_pgood_vcore} = pg_cfg;

    fault_summary_top #(.clocks_per_ms(cpm)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reference model state
    logic [11:0] mon_q, mon_qq;
    logic        em_prev, em_busy, em_pulse;
    logic        sup_f, sup_r, sup_p, mcu_f, mcu_r, wd_a;
    logic        exp_fs0b, exp_rstb, exp_fccu_err, exp_flag;
    int          em_left, inc_q, cnt_m;
    int          sup_n, mcu_n, ev_sum;

    always_comb begin
        sup_f = 1'b0;
        sup_r = 1'b0;
        sup_p = 1'b0;
        sup_n = 0;
        for (int i = 0; i < 12; i++) begin
            if (mon_q[i] && !mon_qq[i]) begin // first edge that saw it high
                if (pg_cfg[i/2]) begin
                    {sup_f, sup_r, sup_p} = 3'b111;
                    sup_n++;
                end else if (imp_cfg[i][1]) begin
                    {sup_f, sup_r} = 2'b11;
                    sup_n++;
                end else if (imp_cfg[i][0]) begin
                    sup_f = 1'b1;
                    sup_n++;
                end
            end
        end
    end

    assign wd_a   = incr_a && (wd_fs_impact != 2'b00);
    assign mcu_f  = fccu1 || fccu2 || fccu12 || wd_a || incr_b;
    assign mcu_r  = (fccu1 && fccu1_fs_impact) || (fccu2 && fccu2_fs_impact)
                 || (fccu12 && fccu12_fs_impact) || (incr_a && wd_fs_impact[1]) || incr_b;
    assign mcu_n  = int'(fccu1) + int'(fccu2) + int'(fccu12) + int'(wd_a) + int'(incr_b);
    assign ev_sum = sup_n + mcu_n + int'(em_pulse);

    assign exp_fs0b = sup_f || mcu_f || em_pulse
                   || (cnt_m == mid_tab[flt_err_cnt_limit] && flt_err_impact != 2'b00);
    assign exp_rstb = sup_r || mcu_r || (em_pulse && errmon_fs_impact)
                   || (cnt_m >= mid_tab[flt_err_cnt_limit] && flt_err_impact[1]);
    assign exp_fccu_err = fccu1 || fccu2 || fccu12;
    assign exp_flag     = (cnt_m == max_tab[flt_err_cnt_limit]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mon_q    <= '0;
            mon_qq   <= '0;
            em_prev  <= 1'b0;
            em_busy  <= 1'b0;
            em_pulse <= 1'b0;
            em_left  <= 0;
            inc_q    <= 0;
            cnt_m    <= 0;
        end else begin
            mon_q    <= mon_bits;
            mon_qq   <= mon_q;
            em_prev  <= errmon;
            em_pulse <= 1'b0;
            if (errmon && !em_prev) begin
                em_busy <= 1'b1;
                em_left <= ms_tab[errmon_ack_time] * cpm; // window in clock cycles
            end else if (em_busy && errmon_ack) begin
                em_busy <= 1'b0;
            end else if (em_busy && em_left == 1) begin
                em_busy  <= 1'b0;
                em_pulse <= 1'b1;
            end else if (em_busy) begin
                em_left <= em_left - 1;
            end
            inc_q <= (ev_sum > 15) ? 15 : ev_sum;
            if (inc_q != 0) begin
                cnt_m <= (cnt_m + inc_q >= max_tab[flt_err_cnt_limit])
                       ? max_tab[flt_err_cnt_limit] : cnt_m + inc_q;
            end else if (decr && cnt_m != 0) begin
                cnt_m <= cnt_m - 1;
            end
        end
    end

    task automatic report_mismatch(input string what, input int got, input int exp);
        $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("Regression failed");
        $fatal(1, "wait timed out");
    endtask

    a_reset_zero: assert property (@(posedge clk)
        !rst_n |-> !(fs0b_active || rstb_active || pgood_active || flag_flt_max || fccu_err)
                   && flt_err_cnt == 4'd0)
        else report_mismatch("an output during reset", 1, 0);
    a_fs0b: assert property (@(posedge clk) disable iff (!rst_n) fs0b_active == exp_fs0b)
        else report_mismatch("fs0b_active", $sampled(fs0b_active), $sampled(exp_fs0b));
    a_rstb: assert property (@(posedge clk) disable iff (!rst_n) rstb_active == exp_rstb)
        else report_mismatch("rstb_active", $sampled(rstb_active), $sampled(exp_rstb));
    a_pgood: assert property (@(posedge clk) disable iff (!rst_n) pgood_active == sup_p)
        else report_mismatch("pgood_active", $sampled(pgood_active), $sampled(sup_p));
    a_fccu_err: assert property (@(posedge clk) disable iff (!rst_n)
        fccu_err == exp_fccu_err)
        else report_mismatch("fccu_err", $sampled(fccu_err), $sampled(exp_fccu_err));
    a_cnt: assert property (@(posedge clk) disable iff (!rst_n) flt_err_cnt == cnt_m)
        else report_mismatch("flt_err_cnt", $sampled(flt_err_cnt), $sampled(cnt_m));
    a_flag: assert property (@(posedge clk) disable iff (!rst_n)
        flag_flt_max == exp_flag)
        else report_mismatch("flag_flt_max", $sampled(flag_flt_max), $sampled(exp_flag));

    task automatic wait_errmon_pulse(input int limit);
        bit seen;
        seen = 1'b0;
        for (int k = 0; k < limit && !seen; k++) begin
            @(negedge clk);
            seen = fs0b_active;
        end
        if (!seen) begin
            abort_on_timeout("no fs0b pulse from the errmon timer");
        end
    endtask

    task automatic count_to_max(input int limit);
        bit seen;
        seen = 1'b0;
        for (int k = 0; k < limit && !seen; k++) begin
            fccu1 = 1'b1; // one event per pulse
            @(negedge clk);
            fccu1 = 1'b0;
            repeat (2) @(negedge clk);
            seen = flag_flt_max;
        end
        if (!seen) begin
            abort_on_timeout("fault error counter never reached its maximum");
        end
    endtask

    task automatic drain_counter(input int limit);
        bit seen;
        decr = 1'b1;
        seen = (flt_err_cnt == 4'd0);
        for (int k = 0; k < limit && !seen; k++) begin
            @(negedge clk);
            seen = (flt_err_cnt == 4'd0);
        end
        if (!seen) begin
            abort_on_timeout("fault error counter did not drain to zero");
        end
        repeat (3) @(negedge clk); // decr at zero must not wrap
        decr = 1'b0;
    endtask

    initial begin
        int r;
        int d;
        seed = 32'h3b1e19fb;
        rst_n = 1'b0;
        mon_bits = '0;
        imp_cfg = '0;
        pg_cfg = '0;
        {fccu1, fccu2, fccu12, incr_a, incr_b, decr} = '0;
        {fccu1_fs_impact, fccu2_fs_impact, fccu12_fs_impact} = '0;
        {errmon, errmon_ack, errmon_fs_impact} = '0;
        errmon_ack_time = 2'b00;
        wd_fs_impact = 2'b00;
        flt_err_impact = 2'b00;
        flt_err_cnt_limit = 2'b11;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // each supply channel under every impact and pgood setting
        for (int ch = 0; ch < 12; ch++) begin
            for (int cfg = 0; cfg < 8; cfg++) begin
                imp_cfg[ch] = cfg[1:0];
                pg_cfg[ch/2] = cfg[2];
                flt_err_impact = 2'($random(seed));
                mon_bits[ch] = 1'b1;
                repeat (1 + $unsigned($random(seed)) % 4) @(negedge clk);
                mon_bits[ch] = 1'b0;
                repeat (2) @(negedge clk);
                drain_counter(20); // next event counts from zero
            end
        end
        for (int n = 0; n < 40; n++) begin // overlapping edges
            mon_bits = 12'($random(seed));
            imp_cfg = 24'($random(seed));
            pg_cfg = 6'($random(seed));
            @(negedge clk);
        end
        mon_bits = '0;
        repeat (2) @(negedge clk);
        drain_counter(20);

        // fccu lines and watchdog
        for (int n = 0; n < 60; n++) begin
            r = $random(seed);
            {fccu1, fccu2, fccu12, incr_a, incr_b, decr} = 6'(r);
            {fccu1_fs_impact, fccu2_fs_impact, fccu12_fs_impact} = 3'(r >> 6);
            wd_fs_impact = 2'(r >> 9);
            flt_err_impact = 2'(r >> 11);
            @(negedge clk);
            {fccu1, fccu2, fccu12, incr_a, incr_b, decr} = '0;
            repeat (2) @(negedge clk); // events land on the counter
            drain_counter(20);
        end
        {fccu1, fccu2, fccu12, incr_a, incr_b, decr} = '0;
        flt_err_impact = 2'b00; // fs0b left to the timer pulse
        repeat (3) @(negedge clk);

        for (int sel = 0; sel < 4; sel++) begin
            errmon_ack_time = 2'(sel);
            errmon_fs_impact = 1'($random(seed));
            errmon = 1'b1;
            @(negedge clk);
            errmon = 1'b0;
            wait_errmon_pulse(ms_tab[sel] * cpm + 10);
            errmon = 1'b1; // acknowledged in time this round
            @(negedge clk);
            errmon = 1'b0;
            d = $unsigned($random(seed)) % (ms_tab[sel] * cpm - 2);
            repeat (d) @(negedge clk);
            errmon_ack = 1'b1;
            @(negedge clk);
            errmon_ack = 1'b0;
            repeat (ms_tab[sel] * cpm + 5) @(negedge clk);
        end

        // saturation, decrement and intermediate action per limit
        for (int lim = 0; lim < 4; lim++) begin
            drain_counter(20);
            flt_err_cnt_limit = 2'(lim);
            flt_err_impact = 2'(lim + 1);
            count_to_max(20);
            for (int k = 0; k < 2; k++) begin
                fccu1 = 1'b1;
                @(negedge clk);
                fccu1 = 1'b0;
                @(negedge clk);
            end
            repeat (2) @(negedge clk);
        end
        drain_counter(20);

        $display("Regression passed");
        $finish;
    end

endmodule
